/* arb_macros.svh */
// sizes and register offsets for the arbiter; ARB_NUM_IN must be a power of two equal to 2**ARB_IDX_W
`ifndef ARB_MACROS_SVH
`define ARB_MACROS_SVH

//////////////////////////////////////////////////
// arbiter sizes
//////////////////////////////////////////////////

// number of requesters on the input side
`define ARB_NUM_IN 8
// width of the requester index, log2 of ARB_NUM_IN
`define ARB_IDX_W 3
// width of the payload carried with each request
`define ARB_DATA_W 32

//////////////////////////////////////////////////
// configuration bus and register map
//////////////////////////////////////////////////

// AXI4-Lite address and data widths
`define AXIL_ADDR_W 4
`define AXIL_DATA_W 32

// control register, bit 0 mode, bit 1 lock enable, bit 2 flush
`define ARB_REG_CTRL 4'h0
// read-only count of completed output handshakes
`define ARB_REG_COUNT 4'h4

`endif

/* arb_pkg.sv */
// arbitration types; widths come from the macro header, so include it before this package
`include "arb_macros.svh"

package arb_pkg;

  // requester index and payload words
  typedef logic [`ARB_IDX_W-1:0]  arb_idx_t;
  typedef logic [`ARB_DATA_W-1:0] arb_data_t;

  //////////////////////////////////////////////////
  // priority update rule
  //////////////////////////////////////////////////

  // rotate advances the pointer by one after every served grant
  // fair jumps to the next active requester above the pointer and wraps
  typedef enum logic {
    ARB_ROTATE = 1'b0,
    ARB_FAIR   = 1'b1
  } arb_mode_e;

  // steering bundle from the register block into the priority controller
  // flush is a single-cycle pulse that clears pointer and lock
  typedef struct packed {
    arb_mode_e mode;
    logic      lock_en;
    logic      flush;
  } arb_cfg_t;

  //////////////////////////////////////////////////
  // arbiter output
  //////////////////////////////////////////////////

  // req is high while any effective request is pending
  // idx names the winning requester and data is its payload
  typedef struct packed {
    logic      req;
    arb_idx_t  idx;
    arb_data_t data;
  } arb_out_t;

endpackage

/* axil_pkg.sv */
// AXI4-Lite channel bundles without prot or id signals; widths come from the macro header
`include "arb_macros.svh"

package axil_pkg;

  typedef logic [`AXIL_ADDR_W-1:0]   axil_addr_t;
  typedef logic [`AXIL_DATA_W-1:0]   axil_data_t;
  typedef logic [`AXIL_DATA_W/8-1:0] axil_strb_t;

  // only the two codes this slave can return
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  //////////////////////////////////////////////////
  // master driven signals
  //////////////////////////////////////////////////

  // write address, write data and read address channels plus both response readies
  typedef struct packed {
    logic       aw_valid;
    axil_addr_t aw_addr;
    logic       w_valid;
    axil_data_t w_data;
    axil_strb_t w_strb;
    logic       b_ready;
    logic       ar_valid;
    axil_addr_t ar_addr;
    logic       r_ready;
  } axil_req_t;

  //////////////////////////////////////////////////
  // slave driven signals
  //////////////////////////////////////////////////

  // channel readies and the two response channels
  typedef struct packed {
    logic       aw_ready;
    logic       w_ready;
    logic       b_valid;
    axil_resp_e b_resp;
    logic       ar_ready;
    logic       r_valid;
    axil_data_t r_data;
    axil_resp_e r_resp;
  } axil_rsp_t;

endpackage

/* arb_cfg_regs.sv */
// AXI4-Lite slave, AW and W must arrive together, one write and one read in flight, only byte 0 of CTRL is writable
`timescale 1ns/1ps
`include "arb_macros.svh"

module arb_cfg_regs (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  axil_pkg::axil_req_t axil_req_i,
  output axil_pkg::axil_rsp_t axil_rsp_o,
  input  logic                handshake_i,
  output arb_pkg::arb_cfg_t   cfg_o
);

  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

  wr_state_e             wr_state_q;
  rd_state_e             rd_state_q;
  logic                  wr_accept;
  logic                  rd_accept;
  logic                  wr_ctrl_hit;
  logic                  wr_count_hit;
  logic                  ctrl_we;
  arb_pkg::arb_mode_e    mode_q;
  logic                  lock_en_q;
  logic [`AXIL_DATA_W-1:0] count_q;
  axil_pkg::axil_resp_e  bresp_q;
  axil_pkg::axil_data_t  rdata_d;
  axil_pkg::axil_data_t  rdata_q;
  axil_pkg::axil_resp_e  rresp_d;
  axil_pkg::axil_resp_e  rresp_q;

  //////////////////////////////////////////////////
  // write channel
  //////////////////////////////////////////////////

  // a write is taken only when address and data are both offered
  assign wr_accept    = (wr_state_q == WR_IDLE) && axil_req_i.aw_valid && axil_req_i.w_valid;
  assign wr_ctrl_hit  = (axil_req_i.aw_addr == `ARB_REG_CTRL);
  assign wr_count_hit = (axil_req_i.aw_addr == `ARB_REG_COUNT);
  assign ctrl_we      = wr_accept && wr_ctrl_hit && axil_req_i.w_strb[0];

  // mode and lock enable land at the acceptance edge, the same edge that raises bvalid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_state_q <= WR_IDLE;
      mode_q     <= arb_pkg::ARB_FAIR;
      lock_en_q  <= 1'b0;
    end else begin
      case (wr_state_q)
        WR_IDLE: begin
          if (wr_accept) begin
            wr_state_q <= WR_RESP;
          end
          if (ctrl_we) begin
            mode_q    <= arb_pkg::arb_mode_e'(axil_req_i.w_data[0]);
            lock_en_q <= axil_req_i.w_data[1];
          end
        end
        default: begin
          if (axil_req_i.b_ready) begin
            wr_state_q <= WR_IDLE;
          end
        end
      endcase
    end
  end

  // COUNT is mapped, a write to it is dropped but still answered OKAY
  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      bresp_q <= (wr_ctrl_hit || wr_count_hit) ? axil_pkg::OKAY : axil_pkg::SLVERR;
    end
  end

  //////////////////////////////////////////////////
  // read channel
  //////////////////////////////////////////////////

  assign rd_accept = (rd_state_q == RD_IDLE) && axil_req_i.ar_valid;

  // flush is a pulse and always reads back as zero
  always_comb begin
    rdata_d = '0;
    rresp_d = axil_pkg::OKAY;
    case (axil_req_i.ar_addr)
      `ARB_REG_CTRL: begin
        rdata_d[0] = mode_q;
        rdata_d[1] = lock_en_q;
      end
      `ARB_REG_COUNT: begin
        rdata_d = count_q;
      end
      default: begin
        rresp_d = axil_pkg::SLVERR;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_state_q <= RD_IDLE;
    end else if (rd_accept) begin
      rd_state_q <= RD_RESP;
    end else if ((rd_state_q == RD_RESP) && axil_req_i.r_ready) begin
      rd_state_q <= RD_IDLE;
    end
  end

  // read data is sampled at acceptance and held until rready
  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      rdata_q <= rdata_d;
      rresp_q <= rresp_d;
    end
  end

  //////////////////////////////////////////////////
  // handshake counter and outputs
  //////////////////////////////////////////////////

  // wraps silently after 2**32 transfers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (handshake_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_comb begin
    axil_rsp_o.aw_ready = wr_accept;
    axil_rsp_o.w_ready  = wr_accept;
    axil_rsp_o.b_valid  = (wr_state_q == WR_RESP);
    axil_rsp_o.b_resp   = bresp_q;
    axil_rsp_o.ar_ready = rd_accept;
    axil_rsp_o.r_valid  = (rd_state_q == RD_RESP);
    axil_rsp_o.r_data   = rdata_q;
    axil_rsp_o.r_resp   = rresp_q;
  end

  // the flush pulse reaches the pointer in the acceptance cycle itself
  assign cfg_o.mode    = mode_q;
  assign cfg_o.lock_en = lock_en_q;
  assign cfg_o.flush   = ctrl_we && axil_req_i.w_data[2];

  // a write response must not be withdrawn before the master takes it
  b_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_rsp_o.b_valid && !axil_req_i.b_ready |=> axil_rsp_o.b_valid)
    else $error("bvalid dropped before bready");

endmodule

/* arb_prio_ctrl.sv */
// priority pointer and lock state; with lock enabled the requesters must hold unserved requests
`timescale 1ns/1ps
`include "arb_macros.svh"

module arb_prio_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  arb_pkg::arb_cfg_t      cfg_i,
  input  logic [`ARB_NUM_IN-1:0] req_i,
  input  arb_pkg::arb_out_t      out_i,
  input  logic                   gnt_i,
  output arb_pkg::arb_idx_t      rr_o,
  output logic [`ARB_NUM_IN-1:0] req_eff_o
);

  arb_pkg::arb_idx_t      rr_q;
  arb_pkg::arb_idx_t      rr_d;
  logic                   lock_q;
  logic                   lock_d;
  logic [`ARB_NUM_IN-1:0] req_q;
  logic                   handshake;
  logic [`ARB_NUM_IN-1:0] upper_mask;
  logic [`ARB_NUM_IN-1:0] lower_mask;
  arb_pkg::arb_idx_t      upper_idx;
  arb_pkg::arb_idx_t      lower_idx;
  logic                   upper_empty;

  // position of the lowest set bit, zero for an empty vector
  function automatic arb_pkg::arb_idx_t lowest_set(input logic [`ARB_NUM_IN-1:0] vec);
    arb_pkg::arb_idx_t pos;
    pos = '0;
    for (int i = `ARB_NUM_IN - 1; i >= 0; i--) begin
      if (vec[i]) begin
        pos = arb_pkg::arb_idx_t'(i);
      end
    end
    return pos;
  endfunction

  //////////////////////////////////////////////////
  // lock-in
  //////////////////////////////////////////////////

  assign handshake = out_i.req && gnt_i;

  // a pending but ungranted output freezes the request set seen by the tree
  assign lock_d    = cfg_i.lock_en && out_i.req && !gnt_i;
  assign req_eff_o = lock_q ? req_q : req_i;

  //////////////////////////////////////////////////
  // next pointer
  //////////////////////////////////////////////////

  // upper holds the candidates strictly above the pointer, lower the rest
  always_comb begin
    for (int i = 0; i < `ARB_NUM_IN; i++) begin
      upper_mask[i] = req_eff_o[i] && (i > int'(rr_q));
      lower_mask[i] = req_eff_o[i] && (i <= int'(rr_q));
    end
  end

  assign upper_idx   = lowest_set(upper_mask);
  assign lower_idx   = lowest_set(lower_mask);
  assign upper_empty = ~|upper_mask;

  // the pointer only moves on a served transfer
  always_comb begin
    rr_d = rr_q;
    if (handshake) begin
      if (cfg_i.mode == arb_pkg::ARB_FAIR) begin
        rr_d = upper_empty ? lower_idx : upper_idx;
      end else if (rr_q == arb_pkg::arb_idx_t'(`ARB_NUM_IN - 1)) begin
        rr_d = '0;
      end else begin
        rr_d = rr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
      req_q  <= '0;
    end else if (cfg_i.flush) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
      req_q  <= '0;
    end else begin
      rr_q   <= rr_d;
      lock_q <= lock_d;
      req_q  <= cfg_i.lock_en ? req_eff_o : '0;
    end
  end

  assign rr_o = rr_q;

  // the winner must survive a stalled cycle once lock-in is on
  lock_idx_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_i.lock_en && out_i.req && !gnt_i && !cfg_i.flush |=> out_i.idx == $past(out_i.idx))
    else $error("arbiter changed its decision while locked");

endmodule

/* arb_tree.sv */
// combinational selection tree for a power-of-two requester count; outputs follow req_i in the same cycle
`timescale 1ns/1ps
`include "arb_macros.svh"

module arb_tree (
  input  logic [`ARB_NUM_IN-1:0]                  req_i,
  input  arb_pkg::arb_idx_t                       rr_i,
  input  logic [`ARB_NUM_IN-1:0][`ARB_DATA_W-1:0] data_i,
  input  logic                                    gnt_i,
  output logic [`ARB_NUM_IN-1:0]                  gnt_o,
  output arb_pkg::arb_out_t                       out_o
);

  localparam int unsigned NumLevels = `ARB_IDX_W;
  localparam int unsigned NumNodes  = (2 ** NumLevels) - 1;

  // node n of level l sits at 2**l-1+n, the root is node 0
  logic [NumNodes-1:0]                         req_nodes;
  logic [NumNodes-1:0]                         gnt_nodes;
  arb_pkg::arb_idx_t [NumNodes-1:0]            idx_nodes;
  logic [NumNodes-1:0][`ARB_DATA_W-1:0]        data_nodes;

  assign gnt_nodes[0] = gnt_i;

  for (genvar lvl = 0; lvl < NumLevels; lvl++) begin : gen_level
    for (genvar n = 0; n < 2 ** lvl; n++) begin : gen_node
      localparam int unsigned Node = (2 ** lvl) - 1 + n;
      // the root decides on the pointer MSB, the leaves on its LSB
      localparam int unsigned Bit  = NumLevels - 1 - lvl;
      logic sel;

      //////////////////////////////////////////////////
      // leaves pair up neighbouring inputs
      //////////////////////////////////////////////////
      if (lvl == NumLevels - 1) begin : gen_leaf
        logic lo_req;
        logic hi_req;

        assign lo_req          = req_i[2*n];
        assign hi_req          = req_i[2*n+1];
        assign req_nodes[Node] = lo_req | hi_req;
        // upper input wins if the lower is idle or the pointer favours it
        assign sel             = ~lo_req | (hi_req & rr_i[Bit]);
        assign idx_nodes[Node] = arb_pkg::arb_idx_t'(sel);
        assign data_nodes[Node] = sel ? data_i[2*n+1] : data_i[2*n];
        // grants are gated by the input's own request
        assign gnt_o[2*n]      = gnt_nodes[Node] & lo_req & ~sel;
        assign gnt_o[2*n+1]    = gnt_nodes[Node] & hi_req & sel;

      //////////////////////////////////////////////////
      // inner nodes merge two subtrees
      //////////////////////////////////////////////////
      end else begin : gen_inner
        localparam int unsigned Child = (2 ** (lvl + 1)) - 1 + 2 * n;

        assign req_nodes[Node] = req_nodes[Child] | req_nodes[Child+1];
        assign sel             = ~req_nodes[Child] | (req_nodes[Child+1] & rr_i[Bit]);
        // this level contributes its own bit on top of the child's lower bits
        assign idx_nodes[Node] = sel ?
          (idx_nodes[Child+1] | (arb_pkg::arb_idx_t'(1) << Bit)) : idx_nodes[Child];
        assign data_nodes[Node] = sel ? data_nodes[Child+1] : data_nodes[Child];
        assign gnt_nodes[Child]   = gnt_nodes[Node] & ~sel;
        assign gnt_nodes[Child+1] = gnt_nodes[Node] & sel;
      end
    end
  end

  assign out_o.req  = req_nodes[0];
  assign out_o.idx  = idx_nodes[0];
  assign out_o.data = data_nodes[0];

  // the grant must reach exactly the leaf that the index names
  always_comb begin
    onehot_a : assert final ($onehot0(gnt_o))
      else $error("more than one input granted");
    if (out_o.req && gnt_i) begin
      gnt_idx_a : assert final (gnt_o[out_o.idx])
        else $error("grant does not match the selected index");
    end
  end

endmodule

/* arb_tree_top.sv */
// arbiter with AXI4-Lite steering; the arbitration path is combinational from req_i to out_o and gnt_o
`timescale 1ns/1ps
`include "arb_macros.svh"

module arb_tree_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic [`ARB_NUM_IN-1:0]                  req_i,
  input  logic [`ARB_NUM_IN-1:0][`ARB_DATA_W-1:0] data_i,
  output logic [`ARB_NUM_IN-1:0]                  gnt_o,
  output arb_pkg::arb_out_t                       out_o,
  input  logic                                    gnt_i,
  input  axil_pkg::axil_req_t                     axil_req_i,
  output axil_pkg::axil_rsp_t                     axil_rsp_o
);

  arb_pkg::arb_cfg_t      cfg;
  arb_pkg::arb_idx_t      rr;
  logic [`ARB_NUM_IN-1:0] req_eff;
  logic                   handshake;

  // a transfer completes whenever the output request meets the consumer grant
  assign handshake = out_o.req && gnt_i;

  // register block that steers mode, lock and flush
  arb_cfg_regs u_cfg_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .axil_req_i  (axil_req_i),
    .axil_rsp_o  (axil_rsp_o),
    .handshake_i (handshake),
    .cfg_o       (cfg)
  );

  // pointer and lock state, sees the tree's own decision
  arb_prio_ctrl u_prio_ctrl (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cfg_i     (cfg),
    .req_i     (req_i),
    .out_i     (out_o),
    .gnt_i     (gnt_i),
    .rr_o      (rr),
    .req_eff_o (req_eff)
  );

  // selection tree works on the effective, possibly locked, requests
  arb_tree u_tree (
    .req_i  (req_eff),
    .rr_i   (rr),
    .data_i (data_i),
    .gnt_i  (gnt_i),
    .gnt_o  (gnt_o),
    .out_o  (out_o)
  );

endmodule

/* arb_checker.sv */
// reference model of arbiter and register block; sees only top-level ports and checks every cycle after reset
`timescale 1ns/1ps
`include "arb_macros.svh"

module arb_checker (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic [`ARB_NUM_IN-1:0]                  req_i,
  input  logic [`ARB_NUM_IN-1:0][`ARB_DATA_W-1:0] data_i,
  input  logic [`ARB_NUM_IN-1:0]                  dut_gnt_i,
  input  arb_pkg::arb_out_t                       out_i,
  input  logic                                    gnt_i,
  input  axil_pkg::axil_req_t                     axil_req_i,
  input  axil_pkg::axil_rsp_t                     axil_rsp_i,
  input  logic                                    exp_chk_i,
  input  logic [`ARB_IDX_W-1:0]                   exp_idx_i,
  output int unsigned                             err_count_o,
  output int unsigned                             check_count_o
);

  int unsigned             errors = 0;
  int unsigned             checks = 0;
  logic [`ARB_IDX_W-1:0]   ptr;
  logic                    lock;
  logic [`ARB_NUM_IN-1:0]  held;
  logic                    mode_fair;
  logic                    lock_en;
  logic [31:0]             count;
  logic [`ARB_NUM_IN-1:0]  eff;
  logic [`ARB_NUM_IN-1:0]  exp_gnt;
  logic [`ARB_IDX_W-1:0]   win;
  logic                    wr_acc;
  logic                    ar_acc;
  logic                    wr_pend;
  logic                    rd_pend;
  logic [31:0]             rd_data;
  logic                    rd_data_chk;
  logic [1:0]              rd_resp;
  logic [1:0]              wr_resp;

  assign err_count_o   = errors;
  assign check_count_o = checks;

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // walk down from the root; the upper half wins when the lower half is idle,
  // or when both halves request and the pointer bit of that level is set
  function automatic logic [`ARB_IDX_W-1:0] tree_pick(input logic [`ARB_NUM_IN-1:0] vec,
                                                      input logic [`ARB_IDX_W-1:0]  p);
    int                     base;
    int                     half;
    logic [`ARB_NUM_IN-1:0] span;
    logic                   lo_any;
    logic                   hi_any;
    base = 0;
    for (int lvl = `ARB_IDX_W - 1; lvl >= 0; lvl--) begin
      half   = 1 << lvl;
      span   = `ARB_NUM_IN'((1 << half) - 1);
      lo_any = |((vec >> base) & span);
      hi_any = |((vec >> (base + half)) & span);
      if (!lo_any || (hi_any && p[lvl])) begin
        base = base + half;
      end
    end
    return `ARB_IDX_W'(base);
  endfunction

  // circular scan starting just above the pointer, so a wrap lands on the lowest active index
  function automatic logic [`ARB_IDX_W-1:0] fair_next(input logic [`ARB_NUM_IN-1:0] vec,
                                                      input logic [`ARB_IDX_W-1:0]  p);
    logic [`ARB_IDX_W-1:0] nxt;
    logic                  found;
    int                    j;
    nxt   = p;
    found = 1'b0;
    for (int i = 1; i <= `ARB_NUM_IN; i++) begin
      j = (int'(p) + i) % `ARB_NUM_IN;
      if (!found && vec[j]) begin
        nxt   = `ARB_IDX_W'(j);
        found = 1'b1;
      end
    end
    return nxt;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr       = '0;
      lock      = 1'b0;
      held      = '0;
      mode_fair = 1'b1;
      lock_en   = 1'b0;
      count     = '0;
      wr_pend   = 1'b0;
      rd_pend   = 1'b0;
    end else begin
      //////////////////////////////////////////////////
      // arbitration outputs of this cycle
      //////////////////////////////////////////////////
      eff     = lock ? held : req_i;
      win     = tree_pick(eff, ptr);
      exp_gnt = (|eff && gnt_i) ? (`ARB_NUM_IN'(1) << win) : '0;
      compare_value("out.req", out_i.req, |eff);
      if (|eff) begin
        compare_value("out.idx", out_i.idx, win);
        compare_value("out.data", out_i.data, data_i[win]);
      end
      compare_value("gnt_o", dut_gnt_i, exp_gnt);
      if (exp_chk_i) begin
        compare_value("table idx", out_i.idx, exp_idx_i);
      end

      //////////////////////////////////////////////////
      // register bus responses
      //////////////////////////////////////////////////
      ar_acc = axil_req_i.ar_valid && axil_rsp_i.ar_ready;
      wr_acc = axil_req_i.aw_valid && axil_req_i.w_valid &&
               axil_rsp_i.aw_ready && axil_rsp_i.w_ready;
      // a response is owed from the edge that accepts a request until its ready is seen
      compare_value("bvalid", axil_rsp_i.b_valid, wr_pend);
      compare_value("rvalid", axil_rsp_i.r_valid, rd_pend);
      // address and data of a write are taken together
      compare_value("wready", axil_rsp_i.w_ready, axil_rsp_i.aw_ready);
      if (axil_rsp_i.r_valid && axil_req_i.r_ready) begin
        compare_value("read resp", axil_rsp_i.r_resp, rd_resp);
        if (rd_data_chk) begin
          compare_value("read data", axil_rsp_i.r_data, rd_data);
        end
      end
      if (axil_rsp_i.b_valid && axil_req_i.b_ready) begin
        compare_value("write resp", axil_rsp_i.b_resp, wr_resp);
      end
      if (wr_pend && axil_req_i.b_ready) begin
        wr_pend = 1'b0;
      end
      if (rd_pend && axil_req_i.r_ready) begin
        rd_pend = 1'b0;
      end
      // read data is taken from the state at acceptance
      if (ar_acc) begin
        rd_pend     = 1'b1;
        rd_data_chk = 1'b1;
        rd_resp     = axil_pkg::OKAY;
        rd_data     = '0;
        if (axil_req_i.ar_addr == `ARB_REG_CTRL) begin
          rd_data = {30'b0, lock_en, mode_fair};
        end else if (axil_req_i.ar_addr == `ARB_REG_COUNT) begin
          rd_data = count;
        end else begin
          rd_data_chk = 1'b0;
          rd_resp     = axil_pkg::SLVERR;
        end
      end
      if (wr_acc) begin
        wr_pend = 1'b1;
        wr_resp = (axil_req_i.aw_addr == `ARB_REG_CTRL ||
                   axil_req_i.aw_addr == `ARB_REG_COUNT) ? axil_pkg::OKAY : axil_pkg::SLVERR;
      end

      //////////////////////////////////////////////////
      // state update with the settings before this edge
      //////////////////////////////////////////////////
      if (|eff && gnt_i) begin
        count = count + 1;
        ptr   = mode_fair ? fair_next(eff, ptr) : ptr + 1'b1;
      end
      held = lock_en ? eff : '0;
      lock = lock_en && |eff && !gnt_i;
      if (wr_acc && axil_req_i.aw_addr == `ARB_REG_CTRL && axil_req_i.w_strb[0]) begin
        mode_fair = axil_req_i.w_data[0];
        lock_en   = axil_req_i.w_data[1];
        // flush beats any pointer move at the same edge
        if (axil_req_i.w_data[2]) begin
          ptr  = '0;
          lock = 1'b0;
          held = '0;
        end
      end
    end
  end

endmodule

/* tb_arb_tree.sv */
// testbench for the arbiter top level; stimulus comes from the step table, all comparing is done by the checker
`timescale 1ns/1ps
`include "arb_macros.svh"

module tb_arb_tree;

  localparam int unsigned TIMEOUT_CYCLES = 20;
  localparam int unsigned NUM_STEPS      = 44;
  localparam logic [1:0]  OP_ARB         = 2'd0;
  localparam logic [1:0]  OP_WRITE       = 2'd1;
  localparam logic [1:0]  OP_READ        = 2'd2;

  // one row: bus access or arbitration cycle, with the index the table expects
  typedef struct packed {
    logic [1:0]              op;
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [`AXIL_DATA_W-1:0] wdata;
    logic [`ARB_NUM_IN-1:0]  req;
    logic                    gnt;
    logic                    chk;
    logic [`ARB_IDX_W-1:0]   idx;
  } step_t;

  //////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////
  // CTRL is bit 0 fair mode, bit 1 lock enable, bit 2 flush
  localparam step_t STEPS [NUM_STEPS] = '{
    '{OP_READ,  4'h0, 32'h0, 8'h00, 1'b0, 1'b0, 3'd0},
    // single requesters in fair mode
    '{OP_ARB,   4'h0, 32'h0, 8'h01, 1'b1, 1'b1, 3'd0},
    '{OP_ARB,   4'h0, 32'h0, 8'h02, 1'b1, 1'b1, 3'd1},
    '{OP_ARB,   4'h0, 32'h0, 8'h04, 1'b1, 1'b1, 3'd2},
    '{OP_ARB,   4'h0, 32'h0, 8'h08, 1'b1, 1'b1, 3'd3},
    '{OP_ARB,   4'h0, 32'h0, 8'h10, 1'b1, 1'b1, 3'd4},
    '{OP_ARB,   4'h0, 32'h0, 8'h20, 1'b1, 1'b1, 3'd5},
    '{OP_ARB,   4'h0, 32'h0, 8'h40, 1'b1, 1'b1, 3'd6},
    '{OP_ARB,   4'h0, 32'h0, 8'h80, 1'b1, 1'b1, 3'd7},
    // flush, then everybody requests in fair mode
    '{OP_WRITE, 4'h0, 32'h5, 8'h00, 1'b0, 1'b0, 3'd0},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd0},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd1},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd2},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd3},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd4},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd5},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd6},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd7},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd0},
    '{OP_READ,  4'h4, 32'h0, 8'h00, 1'b0, 1'b0, 3'd0},
    // lock-in, input 2 keeps the output while new requesters join
    '{OP_WRITE, 4'h0, 32'h3, 8'h00, 1'b0, 1'b0, 3'd0},
    '{OP_ARB,   4'h0, 32'h0, 8'ha4, 1'b0, 1'b1, 3'd2},
    '{OP_ARB,   4'h0, 32'h0, 8'he5, 1'b0, 1'b1, 3'd2},
    '{OP_ARB,   4'h0, 32'h0, 8'he5, 1'b1, 1'b1, 3'd2},
    '{OP_ARB,   4'h0, 32'h0, 8'he1, 1'b1, 1'b1, 3'd0},
    // the fair jump from 2 put the pointer on input 5, the first requester above it
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd5},
    // rotate mode after a flush
    '{OP_WRITE, 4'h0, 32'h4, 8'h00, 1'b0, 1'b0, 3'd0},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd0},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd1},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd2},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd3},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd4},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd5},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd6},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd7},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd0},
    // rotate moves the pointer by one even though input 7 is the next requester
    '{OP_ARB,   4'h0, 32'h0, 8'h81, 1'b1, 1'b1, 3'd0},
    '{OP_ARB,   4'h0, 32'h0, 8'hff, 1'b1, 1'b1, 3'd2},
    // readback, then an unmapped read and write
    '{OP_READ,  4'h0, 32'h0, 8'h00, 1'b0, 1'b0, 3'd0},
    '{OP_WRITE, 4'h0, 32'h3, 8'h00, 1'b0, 1'b0, 3'd0},
    '{OP_READ,  4'h0, 32'h0, 8'h00, 1'b0, 1'b0, 3'd0},
    '{OP_READ,  4'h4, 32'h0, 8'h00, 1'b0, 1'b0, 3'd0},
    '{OP_READ,  4'h8, 32'h0, 8'h00, 1'b0, 1'b0, 3'd0},
    '{OP_WRITE, 4'hc, 32'h1, 8'h00, 1'b0, 1'b0, 3'd0}
  };

  logic                                    clk_i;
  logic                                    rst_ni;
  logic [`ARB_NUM_IN-1:0]                  req;
  logic [`ARB_NUM_IN-1:0][`ARB_DATA_W-1:0] data;
  logic [`ARB_NUM_IN-1:0]                  gnt_out;
  arb_pkg::arb_out_t                       arb_out;
  logic                                    gnt;
  axil_pkg::axil_req_t                     axil_req;
  axil_pkg::axil_rsp_t                     axil_rsp;
  logic                                    exp_chk;
  logic [`ARB_IDX_W-1:0]                   exp_idx;
  int unsigned                             err_count;
  int unsigned                             check_count;
  int unsigned                             timeouts = 0;

  always #5 clk_i = ~clk_i;

  arb_tree_top u_dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req),
    .data_i     (data),
    .gnt_o      (gnt_out),
    .out_o      (arb_out),
    .gnt_i      (gnt),
    .axil_req_i (axil_req),
    .axil_rsp_o (axil_rsp)
  );

  arb_checker u_checker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req),
    .data_i        (data),
    .dut_gnt_i     (gnt_out),
    .out_i         (arb_out),
    .gnt_i         (gnt),
    .axil_req_i    (axil_req),
    .axil_rsp_i    (axil_rsp),
    .exp_chk_i     (exp_chk),
    .exp_idx_i     (exp_idx),
    .err_count_o   (err_count),
    .check_count_o (check_count)
  );

  task automatic note_timeout(input string what);
    timeouts++;
    $display("timeout at %0t: %s", $time, what);
  endtask

  // requesting inputs hold their payload, idle ones get a fresh random word
  task automatic drive_requests(input logic [`ARB_NUM_IN-1:0] vec, input logic grant);
    for (int k = 0; k < `ARB_NUM_IN; k++) begin
      if (!vec[k]) begin
        data[k] = $urandom();
      end
    end
    req = vec;
    gnt = grant;
  endtask

  //////////////////////////////////////////////////
  // AXI4-Lite master
  //////////////////////////////////////////////////
  task automatic axil_write(input logic [`AXIL_ADDR_W-1:0] addr,
                            input logic [`AXIL_DATA_W-1:0] wdata);
    int unsigned waited;
    @(negedge clk_i);
    axil_req.aw_valid = 1'b1;
    axil_req.aw_addr  = addr;
    axil_req.w_valid  = 1'b1;
    axil_req.w_data   = wdata;
    axil_req.w_strb   = '1;
    axil_req.b_ready  = 1'b1;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!axil_rsp.aw_ready && waited < TIMEOUT_CYCLES);
    if (!axil_rsp.aw_ready) begin
      note_timeout("write address and data were never accepted");
    end
    @(negedge clk_i);
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!axil_rsp.b_valid && waited < TIMEOUT_CYCLES);
    if (!axil_rsp.b_valid) begin
      note_timeout("no write response arrived");
    end
    @(negedge clk_i);
    axil_req.b_ready = 1'b0;
  endtask

  task automatic axil_read(input logic [`AXIL_ADDR_W-1:0] addr);
    int unsigned waited;
    @(negedge clk_i);
    axil_req.ar_valid = 1'b1;
    axil_req.ar_addr  = addr;
    axil_req.r_ready  = 1'b1;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!axil_rsp.ar_ready && waited < TIMEOUT_CYCLES);
    if (!axil_rsp.ar_ready) begin
      note_timeout("read address was never accepted");
    end
    @(negedge clk_i);
    axil_req.ar_valid = 1'b0;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!axil_rsp.r_valid && waited < TIMEOUT_CYCLES);
    if (!axil_rsp.r_valid) begin
      note_timeout("no read data arrived");
    end
    @(negedge clk_i);
    axil_req.r_ready = 1'b0;
  endtask

  initial begin
    int unsigned pad;
    void'($urandom(71));
    clk_i    = 1'b0;
    rst_ni   = 1'b0;
    req      = '0;
    data     = '0;
    gnt      = 1'b0;
    axil_req = '0;
    exp_chk  = 1'b0;
    exp_idx  = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    for (int s = 0; s < NUM_STEPS; s++) begin
      @(negedge clk_i);
      if (STEPS[s].op == OP_ARB) begin
        drive_requests(STEPS[s].req, STEPS[s].gnt);
        exp_chk = STEPS[s].chk;
        exp_idx = STEPS[s].idx;
      end else begin
        drive_requests('0, 1'b0);
        exp_chk = 1'b0;
        if (STEPS[s].op == OP_WRITE) begin
          axil_write(STEPS[s].addr, STEPS[s].wdata);
        end else begin
          axil_read(STEPS[s].addr);
        end
      end
      // stalled requests stay up during padding, served ones drop
      pad = $urandom_range(2, 0);
      repeat (pad) begin
        @(negedge clk_i);
        exp_chk = 1'b0;
        drive_requests(gnt ? '0 : req, 1'b0);
      end
    end

    @(negedge clk_i);
    exp_chk = 1'b0;
    drive_requests('0, 1'b0);
    repeat (2) @(negedge clk_i);
    $display("checks %0d, errors %0d, timeouts %0d", check_count, err_count, timeouts);
    if (err_count == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
arb_pkg.sv
axil_pkg.sv
arb_cfg_regs.sv
arb_prio_ctrl.sv
arb_tree.sv
arb_tree_top.sv
arb_checker.sv
tb_arb_tree.sv

/* Makefile */
# Verilator build and run of the arbiter testbench
VERILATOR ?= verilator
TOP       ?= tb_arb_tree
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
